//--- bench/line_filter_stimulus.txt
// Word 0 is the row width and word 1 the number of rows, then one line of pixels per row,
// then one line of expected 3x3 sums per scan, oldest scan first
0006 0006
0010 0011 0012 0013 0014 0015
0020 0021 0022 0023 0024 0025
0030 0031 0032 0033 0034 0035
0040 0041 0042 0043 0044 0045
0050 0051 0052 0053 0054 0055
0060 0061 0062 0063 0064 0065
0129 0132 013B 0144
01B9 01C2 01CB 01D4
0249 0252 025B 0264
02D9 02E2 02EB 02F4

//--- bench/tb_line_filter.sv
`timescale 1ns/1ns

`include "line_defs.svh"

module tb_line_filter;

    logic        clk;
    logic        rst;
    logic [3:0]  s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    logic [3:0]  s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    logic [31:0] s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;
    logic        pix_valid;
    logic [7:0]  pix_data;
    logic        pix_ready;
    logic        sum_valid;
    logic [11:0] sum_data;

    // Row width, row count, pixel rows, then expected sums per scan
    logic [15:0] stim [0:255];
    logic [11:0] sums_seen [$];
    logic [31:0] word;
    integer      seed = 30;
    int          width;
    int          n_rows;
    int          cycles = 0;
    int          cycle_limit = 1000;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_failed = 0;
    int          stalls = 0;

    line_filter_top i_line_filter_top (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Run timed out after %0d cycles before all tests finished", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // Collect every sum mid-cycle
    always @(negedge clk) begin
        if (!rst && sum_valid) begin
            sums_seen.push_back(sum_data);
        end
    end

    function automatic logic [7:0] pixel_at(input int row, input int col);
        int idx;
        idx = 2 + row * width + col;
        return stim[idx[7:0]][7:0];
    endfunction

    function automatic logic [15:0] expected_sum(input int scan, input int j);
        int idx;
        idx = 2 + n_rows * width + scan * (width - 2) + j;
        return stim[idx[7:0]];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        logic taken;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = s_axi_awready && s_axi_wready;
            @(posedge clk);
            #2;
        end
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid) begin
            @(posedge clk);
            #2;
        end
        check_value("bresp", 32'(s_axi_bresp), 32'h0);
        // bready is held high, response ends on this edge
        @(posedge clk);
        #2;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        logic taken;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = s_axi_arready;
            @(posedge clk);
            #2;
        end
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) begin
            @(posedge clk);
            #2;
        end
        data = s_axi_rdata;
        check_value("rresp", 32'(s_axi_rresp), 32'h0);
        @(posedge clk);
        #2;
    endtask

    task automatic send_pixel(input logic [7:0] value);
        logic taken;
        pix_valid = 1'b1;
        pix_data  = value;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = pix_ready;
            if (!taken) begin
                stalls++;
            end
            @(posedge clk);
            #2;
        end
        pix_valid = 1'b0;
    endtask

    // Random idle gaps of zero or one cycle between pixels
    task automatic send_row(input int row);
        int gap;
        for (int c = 0; c < width; c++) begin
            gap = $random(seed) & 1;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            send_pixel(pixel_at(row, c));
        end
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        status = 32'h2;
        while (status[1]) begin
            axi_read(`LINE_REG_STATUS, status);
        end
    endtask

    task automatic collect_scans(input int first_scan, input int n_scans);
        int total;
        int idx;
        total = n_scans * (width - 2);
        while (sums_seen.size() < total) begin
            @(posedge clk);
            #2;
        end
        wait_idle();
        check_value("sum count", sums_seen.size(), total);
        idx = 0;
        for (int s = first_scan; s < first_scan + n_scans; s++) begin
            for (int j = 0; j < width - 2; j++) begin
                if (idx < sums_seen.size()) begin
                    check_value("sum_data", 32'(sums_seen[idx]), 32'(expected_sum(s, j)));
                end
                idx++;
            end
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
        sums_seen.delete();
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == errors_at_start) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", num, name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic run_tests();
        begin_test();
        axi_read(`LINE_REG_STATUS, word);
        check_value("status", word, 32'h0);
        axi_read(`LINE_REG_COUNT, word);
        check_value("scan_count", word, 32'h0);
        axi_read(`LINE_REG_CTRL, word);
        check_value("ctrl", word, 32'h0);
        axi_write(`LINE_REG_WIDTH, width);
        axi_read(`LINE_REG_WIDTH, word);
        check_value("row_width", word, width);
        end_test(1, "register access");

        // Enable still low, so the buffer only fills
        begin_test();
        for (int r = 0; r < `LINE_ROWS; r++) begin
            send_row(r);
        end
        check_value("pix_ready", 32'(pix_ready), 32'h0);
        axi_read(`LINE_REG_STATUS, word);
        check_value("status", word, 32'h1);
        repeat (width + 4) begin
            @(posedge clk);
            #2;
        end
        check_value("sum count", sums_seen.size(), 0);
        end_test(2, "buffering before enable");

        begin_test();
        axi_write(`LINE_REG_CTRL, 32'h1);
        collect_scans(0, 1);
        axi_read(`LINE_REG_COUNT, word);
        check_value("scan_count", word, 32'h1);
        end_test(3, "first scan sums");

        // Fourth row lands in the memory of the first
        begin_test();
        send_row(3);
        collect_scans(1, 1);
        axi_read(`LINE_REG_COUNT, word);
        check_value("scan_count", word, 32'h2);
        end_test(4, "row rotation");

        // Remaining rows back to back, the last one waits on a running scan
        begin_test();
        stalls = 0;
        for (int r = 4; r < n_rows; r++) begin
            send_row(r);
        end
        collect_scans(2, n_rows - 4);
        if (stalls == 0) begin
            $display("No pixel was held back while the line buffer was full");
            errors++;
        end
        axi_read(`LINE_REG_COUNT, word);
        check_value("scan_count", word, n_rows - 2);
        end_test(5, "back-pressure");
    endtask

    initial begin
        rst           = 1'b1;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 4'hF;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b1;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b1;
        pix_valid     = 1'b0;
        pix_data      = '0;
        $readmemh("bench/line_filter_stimulus.txt", stim);
        width       = int'(stim[0]);
        n_rows      = int'(stim[1]);
        cycle_limit = 4 * (`LINE_ROWS + 2) * (width + 8) + 200;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        if (width < 3 || width >= `LINE_MAX_W || n_rows < 5) begin
            $display("Stimulus file is missing or gives an unusable row width or row count");
            $display("Test failed");
            $finish;
        end else begin
            run_tests();
            $display("Tests run: 5, failed: %0d, errors: %0d", tests_failed, errors);
            if (errors == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

//--- rtl/cfg_regs.sv
`timescale 1ns/1ns

`include "line_defs.svh"

module cfg_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  ctrl_pkg::axi_addr_t   awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  ctrl_pkg::axi_data_t   wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  ctrl_pkg::axi_addr_t   araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output ctrl_pkg::axi_data_t   rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  enable,
    output pixel_pkg::row_addr_t  row_width,
    input  logic                  full,
    input  logic                  busy,
    input  ctrl_pkg::scan_count_t scan_count
);
    import ctrl_pkg::*;

    logic      wr_take;
    axi_data_t rd_word;

    // AW and W are taken together, one write in flight
    assign wr_take = awvalid & wvalid & ~bvalid;
    assign awready = wr_take;
    assign wready  = wr_take;
    assign arready = ~rvalid;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable    <= 1'b0;
            row_width <= '0;
            bvalid    <= 1'b0;
        end else begin
            if (wr_take && wstrb[0]) begin
                case (awaddr)
                    `LINE_REG_CTRL:  enable    <= wdata[0];
                    `LINE_REG_WIDTH: row_width <= wdata[`LINE_ADDR_W-1:0];
                    default: ;
                endcase
            end
            if (wr_take) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        case (araddr)
            `LINE_REG_CTRL:   rd_word = {31'b0, enable};
            `LINE_REG_WIDTH:  rd_word = {{(32-`LINE_ADDR_W){1'b0}}, row_width};
            `LINE_REG_STATUS: rd_word = {30'b0, busy, full};
            `LINE_REG_COUNT:  rd_word = {16'b0, scan_count};
            default:          rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= rd_word;
        end
    end

    a_bvalid_held: assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> bvalid);

endmodule

//--- rtl/coupler_if.sv
`timescale 1ns/1ns

interface coupler_if;
    import pixel_pkg::*;

    logic      full;
    logic      rd_en;
    row_addr_t rd_addr;
    logic      rd_last;
    column_t   col;
    logic      col_valid;

    // Row memories side
    modport coupler (
        output full, col, col_valid,
        input  rd_en, rd_addr, rd_last
    );

    // Scan FSM side
    modport scanner (
        input  full,
        output rd_en, rd_addr, rd_last
    );

endinterface

//--- rtl/ctrl_pkg.sv
package ctrl_pkg;

    // Column scan FSM
    typedef enum logic [1:0] {
        st_idle,
        st_scan,
        st_drain
    } scan_state_t;

    // AXI4-Lite address and data words
    typedef logic [3:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;

    // Finished scans since reset
    typedef logic [15:0] scan_count_t;

endpackage

//--- rtl/line_defs.svh
`ifndef LINE_DEFS_SVH
`define LINE_DEFS_SVH

// Datapath geometry
`define LINE_PIX_W  8
`define LINE_ROWS   3
`define LINE_MAX_W  64
`define LINE_ADDR_W 6

// Register map, byte addresses on the AXI4-Lite port
`define LINE_REG_CTRL   4'h0
`define LINE_REG_WIDTH  4'h4
`define LINE_REG_STATUS 4'h8
`define LINE_REG_COUNT  4'hC

`endif

//--- rtl/line_filter_top.sv
`timescale 1ns/1ns

module line_filter_top (
    input  logic                clk,
    input  logic                rst,
    input  ctrl_pkg::axi_addr_t s_axi_awaddr,
    input  logic                s_axi_awvalid,
    output logic                s_axi_awready,
    input  ctrl_pkg::axi_data_t s_axi_wdata,
    input  logic [3:0]          s_axi_wstrb,
    input  logic                s_axi_wvalid,
    output logic                s_axi_wready,
    output logic [1:0]          s_axi_bresp,
    output logic                s_axi_bvalid,
    input  logic                s_axi_bready,
    input  ctrl_pkg::axi_addr_t s_axi_araddr,
    input  logic                s_axi_arvalid,
    output logic                s_axi_arready,
    output ctrl_pkg::axi_data_t s_axi_rdata,
    output logic [1:0]          s_axi_rresp,
    output logic                s_axi_rvalid,
    input  logic                s_axi_rready,
    input  logic                pix_valid,
    input  pixel_pkg::pixel_t   pix_data,
    output logic                pix_ready,
    output logic                sum_valid,
    output pixel_pkg::sum_t     sum_data
);
    import pixel_pkg::*;
    import ctrl_pkg::*;

    logic        enable;
    logic        busy;
    row_addr_t   row_width;
    scan_count_t scan_count;

    coupler_if i_bus ();

    cfg_regs i_cfg_regs (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (s_axi_awaddr),
        .awvalid    (s_axi_awvalid),
        .awready    (s_axi_awready),
        .wdata      (s_axi_wdata),
        .wstrb      (s_axi_wstrb),
        .wvalid     (s_axi_wvalid),
        .wready     (s_axi_wready),
        .bresp      (s_axi_bresp),
        .bvalid     (s_axi_bvalid),
        .bready     (s_axi_bready),
        .araddr     (s_axi_araddr),
        .arvalid    (s_axi_arvalid),
        .arready    (s_axi_arready),
        .rdata      (s_axi_rdata),
        .rresp      (s_axi_rresp),
        .rvalid     (s_axi_rvalid),
        .rready     (s_axi_rready),
        .enable     (enable),
        .row_width  (row_width),
        .full       (i_bus.full),
        .busy       (busy),
        .scan_count (scan_count)
    );

    row_coupler i_row_coupler (
        .clk       (clk),
        .rst       (rst),
        .row_width (row_width),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready),
        .bus       (i_bus.coupler)
    );

    scan_ctrl i_scan_ctrl (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .row_width  (row_width),
        .busy       (busy),
        .scan_count (scan_count),
        .bus        (i_bus.scanner)
    );

    window_sum i_window_sum (
        .clk       (clk),
        .rst       (rst),
        .col       (i_bus.col),
        .col_valid (i_bus.col_valid),
        .sum_valid (sum_valid),
        .sum_data  (sum_data)
    );

endmodule

//--- rtl/pixel_pkg.sv
`include "line_defs.svh"

package pixel_pkg;

    // One pixel
    typedef logic [`LINE_PIX_W-1:0] pixel_t;

    // ROWS pixels of one column, oldest row in the lowest slot
    typedef logic [`LINE_ROWS*`LINE_PIX_W-1:0] column_t;

    // Nine pixels need four bits above the pixel width
    typedef logic [`LINE_PIX_W+3:0] sum_t;

    // Column index within a row
    typedef logic [`LINE_ADDR_W-1:0] row_addr_t;

endpackage

//--- rtl/row_coupler.sv
`timescale 1ns/1ns

`include "line_defs.svh"

module row_coupler (
    input  logic                 clk,
    input  logic                 rst,
    input  pixel_pkg::row_addr_t row_width,
    input  logic                 pix_valid,
    input  pixel_pkg::pixel_t    pix_data,
    output logic                 pix_ready,
    coupler_if.coupler           bus
);
    import pixel_pkg::*;

    localparam int PTR_W = $clog2(`LINE_ROWS);

    logic [PTR_W-1:0]      wr_ptr;
    row_addr_t             wr_addr;
    logic [`LINE_ROWS-1:0] row_full;
    logic                  pix_take;
    logic                  row_done;
    pixel_t                rd_data [`LINE_ROWS];

    assign bus.full  = &row_full;
    assign pix_ready = ~bus.full;
    assign pix_take  = pix_valid & pix_ready;
    assign row_done  = pix_take & (wr_addr == row_width - 1'b1);

    for (genvar i = 0; i < `LINE_ROWS; i++) begin : g_row
        row_ram i_row_ram (
            .clk     (clk),
            .wr_en   (pix_take && (wr_ptr == PTR_W'(i))),
            .wr_addr (wr_addr),
            .wr_data (pix_data),
            .rd_en   (bus.rd_en),
            .rd_addr (bus.rd_addr),
            .rd_data (rd_data[i])
        );
    end

    // Write pointer always sits on the oldest row once all rows are full
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            wr_addr  <= '0;
            row_full <= '0;
        end else begin
            if (row_done) begin
                wr_addr          <= '0;
                row_full[wr_ptr] <= 1'b1;
                wr_ptr           <= (wr_ptr == PTR_W'(`LINE_ROWS - 1)) ? '0 : wr_ptr + 1'b1;
            end else if (pix_take) begin
                wr_addr <= wr_addr + 1'b1;
            end
            // Last column read frees the oldest row
            if (bus.rd_en && bus.rd_last) begin
                row_full[wr_ptr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.col_valid <= 1'b0;
        end else begin
            bus.col_valid <= bus.rd_en;
        end
    end

    // Slot k takes row wr_ptr+k, so the oldest row lands in slot 0
    always_comb begin
        bus.col = '0;
        for (int k = 0; k < `LINE_ROWS; k++) begin
            bus.col[k*`LINE_PIX_W +: `LINE_PIX_W] = rd_data[(int'(wr_ptr) + k) % `LINE_ROWS];
        end
    end

    a_full_blocks_write: assert property (@(posedge clk) disable iff (rst)
        pix_take |-> !row_full[wr_ptr]);

    a_read_needs_full: assert property (@(posedge clk) disable iff (rst)
        bus.rd_en |-> bus.full);

endmodule

//--- rtl/row_ram.sv
`timescale 1ns/1ns

`include "line_defs.svh"

module row_ram (
    input  logic                 clk,
    input  logic                 wr_en,
    input  pixel_pkg::row_addr_t wr_addr,
    input  pixel_pkg::pixel_t    wr_data,
    input  logic                 rd_en,
    input  pixel_pkg::row_addr_t rd_addr,
    output pixel_pkg::pixel_t    rd_data
);
    import pixel_pkg::*;

    pixel_t mem [`LINE_MAX_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- rtl/scan_ctrl.sv
`timescale 1ns/1ns

module scan_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  pixel_pkg::row_addr_t  row_width,
    output logic                  busy,
    output ctrl_pkg::scan_count_t scan_count,
    coupler_if.scanner            bus
);
    import ctrl_pkg::*;

    scan_state_t state;
    logic        last_col;

    assign last_col    = (bus.rd_addr == row_width - 1'b1);
    assign bus.rd_en   = (state == st_scan);
    assign bus.rd_last = bus.rd_en & last_col;
    assign busy        = (state != st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            bus.rd_addr <= '0;
            scan_count  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    bus.rd_addr <= '0;
                    if (bus.full && enable) begin
                        state <= st_scan;
                    end
                end
                st_scan: begin
                    if (last_col) begin
                        bus.rd_addr <= '0;
                        state       <= st_drain;
                    end else begin
                        bus.rd_addr <= bus.rd_addr + 1'b1;
                    end
                end
                // One cycle for the freed row flag to settle before idle
                st_drain: begin
                    scan_count <= scan_count + 1'b1;
                    state      <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    a_addr_in_row: assert property (@(posedge clk) disable iff (rst)
        (state == st_scan) |-> (bus.rd_addr < row_width));

endmodule

//--- rtl/window_sum.sv
`timescale 1ns/1ns

`include "line_defs.svh"

module window_sum (
    input  logic               clk,
    input  logic               rst,
    input  pixel_pkg::column_t col,
    input  logic               col_valid,
    output logic               sum_valid,
    output pixel_pkg::sum_t    sum_data
);
    import pixel_pkg::*;

    sum_t       col_sum;
    sum_t       hist [2];
    logic [1:0] col_cnt;

    always_comb begin
        col_sum = '0;
        for (int k = 0; k < `LINE_ROWS; k++) begin
            col_sum = col_sum + sum_t'(col[k*`LINE_PIX_W +: `LINE_PIX_W]);
        end
    end

    // Two held column sums plus the incoming one form the window
    always_ff @(posedge clk) begin
        if (col_valid) begin
            hist[0] <= col_sum;
            hist[1] <= hist[0];
        end
        if (col_valid && col_cnt == 2'd2) begin
            sum_data <= col_sum + hist[0] + hist[1];
        end
    end

    // Column count saturates at two, cleared between scans
    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt   <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= col_valid && (col_cnt == 2'd2);
            if (!col_valid) begin
                col_cnt <= '0;
            end else if (col_cnt != 2'd2) begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_line_filter -f verilog.f
./obj_dir/Vtb_line_filter | tee sim.log
if grep -qx "Test completed successfully" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

//--- verilog.f
+incdir+rtl
rtl/pixel_pkg.sv
rtl/ctrl_pkg.sv
rtl/coupler_if.sv
rtl/row_ram.sv
rtl/row_coupler.sv
rtl/scan_ctrl.sv
rtl/window_sum.sv
rtl/cfg_regs.sv
rtl/line_filter_top.sv
bench/tb_line_filter.sv
